// File: design/rn_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register counts, index widths and free-list sizing
// for the rename stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef RN_CONSTS_SVH
`define RN_CONSTS_SVH

// Register file sizes
`define RN_ARCH_REGS 32
`define RN_PHYS_REGS 64

// Index widths
`define RN_ARCH_W 5
`define RN_PREG_W 6

// Free list holds every physical register not mapped at reset
`define RN_FREE_DEPTH 32
`define RN_FREE_CNT_W 6

// Packed slot is rs1, rs2, dest and the write flag
`define RN_SLOT_W 16
// Two slots plus the ins1 valid bit
`define RN_BUNDLE_W 33

`endif

// File: design/rn_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector types shared across the rename stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "rn_consts.svh"

package rn_pkg;

  // Architectural register index
  typedef logic [`RN_ARCH_W-1:0] arch_reg_t;

  // Physical register index
  typedef logic [`RN_PREG_W-1:0] preg_t;

  // Free-list occupancy, 0 up to full depth
  typedef logic [`RN_FREE_CNT_W-1:0] free_cnt_t;

  // Bundle as held in the input skid buffer.
  // Layout from msb: ins0 {rs1, rs2, dest, wr}, ins1 {rs1, rs2, dest, wr}, ins1_valid
  typedef logic [`RN_BUNDLE_W-1:0] bundle_t;

endpackage

`default_nettype wire

// File: design/rn_skid_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-entry skid buffer with registered ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module rn_skid_buffer #(
  parameter int DATA_W = 8
) (
  input  wire logic              cpu_clock_i,
  input  wire logic              rst_i,
  input  wire logic              in_valid_i,
  output logic                   in_ready_o,
  input  wire logic [DATA_W-1:0] in_data_i,
  output logic                   out_valid_o,
  input  wire logic              out_ready_i,
  output logic      [DATA_W-1:0] out_data_o
);
  logic              main_valid;
  logic [DATA_W-1:0] main_data;
  logic              spare_valid;
  logic [DATA_W-1:0] spare_data;
  logic              in_fire;
  logic              main_free;
  logic              spare_valid_nxt;

  assign in_fire   = in_valid_i & in_ready_o;
  // Main entry is empty or drains on this edge
  assign main_free = ~main_valid | out_ready_i;

  // Spare only fills when the consumer stalls on a full main entry
  assign spare_valid_nxt = main_free ? 1'b0 : (spare_valid | in_fire);

  always_ff @(posedge cpu_clock_i) begin
    if (rst_i) begin
      main_valid  <= 1'b0;
      spare_valid <= 1'b0;
      in_ready_o  <= 1'b0;
    end else begin
      if (main_free) begin
        main_valid <= spare_valid | in_fire;
      end
      spare_valid <= spare_valid_nxt;
      in_ready_o  <= ~spare_valid_nxt;
    end
  end

  always_ff @(posedge cpu_clock_i) begin
    if (main_free) begin
      // Spare is older, so it goes first
      main_data <= spare_valid ? spare_data : in_data_i;
    end else if (in_fire) begin
      spare_data <= in_data_i;
    end
  end

  assign out_valid_o = main_valid;
  assign out_data_o  = main_data;

  a_hold_stable: assert property (@(posedge cpu_clock_i) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
    else $error("skid buffer output changed while stalled");

endmodule

`default_nettype wire

// File: design/rn_map_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Speculative map table with in-bundle bypass
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "rn_consts.svh"

module rn_map_table (
  input  wire logic              cpu_clock_i,
  input  wire logic              rst_i,
  input  wire rn_pkg::arch_reg_t ins0_rs1_i,
  input  wire rn_pkg::arch_reg_t ins0_rs2_i,
  input  wire rn_pkg::arch_reg_t ins0_dest_i,
  input  wire rn_pkg::arch_reg_t ins1_rs1_i,
  input  wire rn_pkg::arch_reg_t ins1_rs2_i,
  input  wire rn_pkg::arch_reg_t ins1_dest_i,
  input  wire logic              alloc0_i,
  input  wire logic              alloc1_i,
  input  wire rn_pkg::preg_t     new0_i,
  input  wire rn_pkg::preg_t     new1_i,
  input  wire logic              we_i,
  output rn_pkg::preg_t          ins0_src1_o,
  output rn_pkg::preg_t          ins0_src2_o,
  output rn_pkg::preg_t          ins1_src1_o,
  output rn_pkg::preg_t          ins1_src2_o,
  output rn_pkg::preg_t          ins0_old_o,
  output rn_pkg::preg_t          ins1_old_o
);
  import rn_pkg::*;

  preg_t map_q [`RN_ARCH_REGS];
  logic  ins1_rs1_hit;
  logic  ins1_rs2_hit;
  logic  ins1_dest_hit;

  // ins1 operands that ins0 redefines in the same bundle
  assign ins1_rs1_hit  = alloc0_i && (ins1_rs1_i == ins0_dest_i);
  assign ins1_rs2_hit  = alloc0_i && (ins1_rs2_i == ins0_dest_i);
  assign ins1_dest_hit = alloc0_i && (ins1_dest_i == ins0_dest_i);

  // Entry 0 never changes, so x0 sources read preg 0 directly
  assign ins0_src1_o = map_q[ins0_rs1_i];
  assign ins0_src2_o = map_q[ins0_rs2_i];
  assign ins1_src1_o = ins1_rs1_hit ? new0_i : map_q[ins1_rs1_i];
  assign ins1_src2_o = ins1_rs2_hit ? new0_i : map_q[ins1_rs2_i];

  // Old mapping is what retire frees later, preg 0 when nothing allocates
  assign ins0_old_o = alloc0_i ? map_q[ins0_dest_i] : '0;

  always_comb begin
    if (!alloc1_i) begin
      ins1_old_o = '0;
    end else if (ins1_dest_hit) begin
      ins1_old_o = new0_i;
    end else begin
      ins1_old_o = map_q[ins1_dest_i];
    end
  end

  always_ff @(posedge cpu_clock_i) begin
    if (rst_i) begin
      // Identity mapping
      for (int i = 0; i < `RN_ARCH_REGS; i++) begin
        map_q[i] <= preg_t'(i);
      end
    end else if (we_i) begin
      if (alloc0_i) begin
        map_q[ins0_dest_i] <= new0_i;
      end
      // Younger write lands last when both slots target one register
      if (alloc1_i) begin
        map_q[ins1_dest_i] <= new1_i;
      end
    end
  end

  a_zero_fixed: assert property (@(posedge cpu_clock_i) disable iff (rst_i)
    map_q[0] == '0)
    else $error("map table entry 0 was renamed");

endmodule

`default_nettype wire

// File: design/rn_free_list.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Free physical register FIFO
// two pops, one retire push per cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "rn_consts.svh"

module rn_free_list (
  input  wire logic          cpu_clock_i,
  input  wire logic          rst_i,
  input  wire logic [1:0]    need_i,
  input  wire logic          pop_i,
  output logic               free_ok_o,
  output rn_pkg::preg_t      head0_o,
  output rn_pkg::preg_t      head1_o,
  input  wire logic          free_valid_i,
  input  wire rn_pkg::preg_t free_preg_i
);
  import rn_pkg::*;

  localparam int PTR_W = $clog2(`RN_FREE_DEPTH);
  // First physical register not covered by the identity map
  localparam int FIRST_FREE = `RN_PHYS_REGS - `RN_FREE_DEPTH;

  preg_t            fifo_q [`RN_FREE_DEPTH];
  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] head_nxt1;
  logic [PTR_W-1:0] tail_q;
  free_cnt_t        count_q;
  logic [1:0]       pop_cnt;

  // Pointers wrap at the buffer depth
  assign head_nxt1 = head_q + PTR_W'(1);

  assign head0_o = fifo_q[head_q];
  assign head1_o = fifo_q[head_nxt1];

  // Enough registers for the whole bundle, or nothing is taken
  assign free_ok_o = count_q >= free_cnt_t'(need_i);

  assign pop_cnt = pop_i ? need_i : 2'd0;

  always_ff @(posedge cpu_clock_i) begin
    if (rst_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= free_cnt_t'(`RN_FREE_DEPTH);
      // Starts full, in ascending order
      for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
        fifo_q[i] <= preg_t'(FIRST_FREE + i);
      end
    end else begin
      head_q  <= head_q + PTR_W'(pop_cnt);
      count_q <= count_q + free_cnt_t'(free_valid_i) - free_cnt_t'(pop_cnt);
      if (free_valid_i) begin
        fifo_q[tail_q] <= free_preg_i;
        tail_q         <= tail_q + PTR_W'(1);
      end
    end
  end

  // Retire only returns registers that were handed out
  a_no_push_full: assert property (@(posedge cpu_clock_i) disable iff (rst_i)
    free_valid_i |-> count_q != free_cnt_t'(`RN_FREE_DEPTH))
    else $error("free list push while full");

  a_pop_ok: assert property (@(posedge cpu_clock_i) disable iff (rst_i)
    pop_i |-> free_ok_o)
    else $error("free list popped without enough registers");

endmodule

`default_nettype wire

// File: design/rn_dispatch_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output register for one renamed bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module rn_dispatch_reg (
  input  wire logic          cpu_clock_i,
  input  wire logic          rst_i,
  input  wire logic          load_i,
  output logic               ready_o,
  input  wire rn_pkg::preg_t ins0_rs1_preg_i,
  input  wire rn_pkg::preg_t ins0_rs2_preg_i,
  input  wire rn_pkg::preg_t ins0_new_preg_i,
  input  wire rn_pkg::preg_t ins0_old_preg_i,
  input  wire logic          ins0_alloc_i,
  input  wire rn_pkg::preg_t ins1_rs1_preg_i,
  input  wire rn_pkg::preg_t ins1_rs2_preg_i,
  input  wire rn_pkg::preg_t ins1_new_preg_i,
  input  wire rn_pkg::preg_t ins1_old_preg_i,
  input  wire logic          ins1_alloc_i,
  input  wire logic          ins1_valid_i,
  output logic               out_valid_o,
  input  wire logic          out_ready_i,
  output rn_pkg::preg_t      ins0_rs1_preg_o,
  output rn_pkg::preg_t      ins0_rs2_preg_o,
  output rn_pkg::preg_t      ins0_new_preg_o,
  output rn_pkg::preg_t      ins0_old_preg_o,
  output logic               ins0_alloc_o,
  output rn_pkg::preg_t      ins1_rs1_preg_o,
  output rn_pkg::preg_t      ins1_rs2_preg_o,
  output rn_pkg::preg_t      ins1_new_preg_o,
  output rn_pkg::preg_t      ins1_old_preg_o,
  output logic               ins1_alloc_o,
  output logic               ins1_valid_o
);

  // Accept a new bundle when empty or when the held one leaves this edge
  assign ready_o = ~out_valid_o | out_ready_i;

  always_ff @(posedge cpu_clock_i) begin
    if (rst_i) begin
      out_valid_o  <= 1'b0;
      ins0_alloc_o <= 1'b0;
      ins1_alloc_o <= 1'b0;
      ins1_valid_o <= 1'b0;
    end else if (load_i) begin
      out_valid_o  <= 1'b1;
      ins0_alloc_o <= ins0_alloc_i;
      ins1_alloc_o <= ins1_alloc_i;
      ins1_valid_o <= ins1_valid_i;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge cpu_clock_i) begin
    if (load_i) begin
      ins0_rs1_preg_o <= ins0_rs1_preg_i;
      ins0_rs2_preg_o <= ins0_rs2_preg_i;
      ins0_new_preg_o <= ins0_new_preg_i;
      ins0_old_preg_o <= ins0_old_preg_i;
      ins1_rs1_preg_o <= ins1_rs1_preg_i;
      ins1_rs2_preg_o <= ins1_rs2_preg_i;
      ins1_new_preg_o <= ins1_new_preg_i;
      ins1_old_preg_o <= ins1_old_preg_i;
    end
  end

endmodule

`default_nettype wire

// File: design/rename_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-wide register rename stage top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "rn_consts.svh"

module rename_stage (
  input  wire logic              cpu_clock_i,
  input  wire logic              rst_i,
  // Incoming bundle
  input  wire logic              in_valid_i,
  output logic                   in_ready_o,
  input  wire rn_pkg::arch_reg_t ins0_rs1_i,
  input  wire rn_pkg::arch_reg_t ins0_rs2_i,
  input  wire rn_pkg::arch_reg_t ins0_dest_i,
  input  wire logic              ins0_wr_i,
  input  wire rn_pkg::arch_reg_t ins1_rs1_i,
  input  wire rn_pkg::arch_reg_t ins1_rs2_i,
  input  wire rn_pkg::arch_reg_t ins1_dest_i,
  input  wire logic              ins1_wr_i,
  input  wire logic              ins1_valid_i,
  // Registers returned by retire
  input  wire logic              free_valid_i,
  input  wire rn_pkg::preg_t     free_preg_i,
  // Renamed bundle
  output logic                   out_valid_o,
  input  wire logic              out_ready_i,
  output rn_pkg::preg_t          ins0_rs1_preg_o,
  output rn_pkg::preg_t          ins0_rs2_preg_o,
  output rn_pkg::preg_t          ins0_new_preg_o,
  output rn_pkg::preg_t          ins0_old_preg_o,
  output logic                   ins0_alloc_o,
  output rn_pkg::preg_t          ins1_rs1_preg_o,
  output rn_pkg::preg_t          ins1_rs2_preg_o,
  output rn_pkg::preg_t          ins1_new_preg_o,
  output rn_pkg::preg_t          ins1_old_preg_o,
  output logic                   ins1_alloc_o,
  output logic                   ins1_valid_o
);
  import rn_pkg::*;

  bundle_t   in_bundle;
  bundle_t   skid_data;
  logic      skid_valid;
  arch_reg_t s_ins0_rs1;
  arch_reg_t s_ins0_rs2;
  arch_reg_t s_ins0_dest;
  logic      s_ins0_wr;
  arch_reg_t s_ins1_rs1;
  arch_reg_t s_ins1_rs2;
  arch_reg_t s_ins1_dest;
  logic      s_ins1_wr;
  logic      s_ins1_valid;
  logic      alloc0;
  logic      alloc1;
  logic [1:0] need;
  logic      free_ok;
  logic      dispatch_ready;
  logic      fire;
  preg_t     head0;
  preg_t     head1;
  preg_t     new0;
  preg_t     new1;
  preg_t     ins0_src1;
  preg_t     ins0_src2;
  preg_t     ins1_src1;
  preg_t     ins1_src2;
  preg_t     ins0_old;
  preg_t     ins1_old;

  assign in_bundle = {ins0_rs1_i, ins0_rs2_i, ins0_dest_i, ins0_wr_i,
                      ins1_rs1_i, ins1_rs2_i, ins1_dest_i, ins1_wr_i, ins1_valid_i};

  rn_skid_buffer #(
    .DATA_W(`RN_BUNDLE_W)
  ) u_skid (
    .cpu_clock_i(cpu_clock_i),
    .rst_i      (rst_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_data_i  (in_bundle),
    .out_valid_o(skid_valid),
    .out_ready_i(fire),
    .out_data_o (skid_data)
  );

  assign {s_ins0_rs1, s_ins0_rs2, s_ins0_dest, s_ins0_wr,
          s_ins1_rs1, s_ins1_rs2, s_ins1_dest, s_ins1_wr, s_ins1_valid} = skid_data;

  // x0 is hardwired, so writes to it take no register
  assign alloc0 = s_ins0_wr && (s_ins0_dest != '0);
  assign alloc1 = s_ins1_valid && s_ins1_wr && (s_ins1_dest != '0);
  assign need   = {1'b0, alloc0} + {1'b0, alloc1};

  // Whole bundle renames at once or waits
  assign fire = skid_valid & dispatch_ready & free_ok;

  // First popped register goes to the first slot that allocates
  assign new0 = alloc0 ? head0 : '0;
  assign new1 = !alloc1 ? '0 : (alloc0 ? head1 : head0);

  rn_free_list u_free_list (
    .cpu_clock_i (cpu_clock_i),
    .rst_i       (rst_i),
    .need_i      (need),
    .pop_i       (fire),
    .free_ok_o   (free_ok),
    .head0_o     (head0),
    .head1_o     (head1),
    .free_valid_i(free_valid_i),
    .free_preg_i (free_preg_i)
  );

  rn_map_table u_map_table (
    .cpu_clock_i(cpu_clock_i),
    .rst_i      (rst_i),
    .ins0_rs1_i (s_ins0_rs1),
    .ins0_rs2_i (s_ins0_rs2),
    .ins0_dest_i(s_ins0_dest),
    .ins1_rs1_i (s_ins1_rs1),
    .ins1_rs2_i (s_ins1_rs2),
    .ins1_dest_i(s_ins1_dest),
    .alloc0_i   (alloc0),
    .alloc1_i   (alloc1),
    .new0_i     (new0),
    .new1_i     (new1),
    .we_i       (fire),
    .ins0_src1_o(ins0_src1),
    .ins0_src2_o(ins0_src2),
    .ins1_src1_o(ins1_src1),
    .ins1_src2_o(ins1_src2),
    .ins0_old_o (ins0_old),
    .ins1_old_o (ins1_old)
  );

  rn_dispatch_reg u_dispatch (
    .cpu_clock_i    (cpu_clock_i),
    .rst_i          (rst_i),
    .load_i         (fire),
    .ready_o        (dispatch_ready),
    .ins0_rs1_preg_i(ins0_src1),
    .ins0_rs2_preg_i(ins0_src2),
    .ins0_new_preg_i(new0),
    .ins0_old_preg_i(ins0_old),
    .ins0_alloc_i   (alloc0),
    .ins1_rs1_preg_i(ins1_src1),
    .ins1_rs2_preg_i(ins1_src2),
    .ins1_new_preg_i(new1),
    .ins1_old_preg_i(ins1_old),
    .ins1_alloc_i   (alloc1),
    .ins1_valid_i   (s_ins1_valid),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .ins0_rs1_preg_o(ins0_rs1_preg_o),
    .ins0_rs2_preg_o(ins0_rs2_preg_o),
    .ins0_new_preg_o(ins0_new_preg_o),
    .ins0_old_preg_o(ins0_old_preg_o),
    .ins0_alloc_o   (ins0_alloc_o),
    .ins1_rs1_preg_o(ins1_rs1_preg_o),
    .ins1_rs2_preg_o(ins1_rs2_preg_o),
    .ins1_new_preg_o(ins1_new_preg_o),
    .ins1_old_preg_o(ins1_old_preg_o),
    .ins1_alloc_o   (ins1_alloc_o),
    .ins1_valid_o   (ins1_valid_o)
  );

endmodule

`default_nettype wire

// File: tests/tb_rename_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Rename stage testbench: stimulus table, reference
// rename model, bundle driver and output monitor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

`include "rn_consts.svh"

module tb_rename_stage;
  import rn_pkg::*;

  localparam int NUM_ROWS    = 40;
  localparam int NUM_FIELDS  = 11;
  localparam int CYCLE_LIMIT = 16 + 10 * NUM_ROWS;

  logic      cpu_clock;
  logic      rst;
  logic      in_valid;
  logic      in_ready;
  arch_reg_t ins0_rs1, ins0_rs2, ins0_dest;
  arch_reg_t ins1_rs1, ins1_rs2, ins1_dest;
  logic      ins0_wr, ins1_wr, ins1_valid;
  logic      free_valid;
  preg_t     free_preg;
  logic      out_valid;
  logic      out_ready;
  preg_t     o0_rs1, o0_rs2, o0_new, o0_old;
  preg_t     o1_rs1, o1_rs2, o1_new, o1_old;
  logic      o0_alloc, o1_alloc, o1_valid;
  logic [50:0] out_word;
  logic [50:0] held_word;

  // Stimulus table and expected outputs per row
  string     row_name [NUM_ROWS];
  arch_reg_t t0_rs1 [NUM_ROWS], t0_rs2 [NUM_ROWS], t0_dest [NUM_ROWS];
  arch_reg_t t1_rs1 [NUM_ROWS], t1_rs2 [NUM_ROWS], t1_dest [NUM_ROWS];
  bit        t0_wr [NUM_ROWS], t1_wr [NUM_ROWS], t1_valid [NUM_ROWS];
  bit        t_free [NUM_ROWS], t_stall [NUM_ROWS];
  preg_t     t_free_reg [NUM_ROWS];
  int        exp_val [NUM_ROWS][NUM_FIELDS];
  string     field_name [NUM_FIELDS] = '{"ins0_rs1", "ins0_rs2", "ins0_new", "ins0_old",
    "ins0_alloc", "ins1_rs1", "ins1_rs2", "ins1_new", "ins1_old", "ins1_alloc", "ins1_valid"};

  int row_cnt   = 0;
  int out_cnt   = 0;
  int errors    = 0;
  int checks    = 0;
  int cycle_cnt = 0;
  bit seen [`RN_PHYS_REGS];
  bit holding   = 1'b0;

  rename_stage UUT (
    .cpu_clock_i(cpu_clock), .rst_i(rst),
    .in_valid_i(in_valid), .in_ready_o(in_ready),
    .ins0_rs1_i(ins0_rs1), .ins0_rs2_i(ins0_rs2), .ins0_dest_i(ins0_dest), .ins0_wr_i(ins0_wr),
    .ins1_rs1_i(ins1_rs1), .ins1_rs2_i(ins1_rs2), .ins1_dest_i(ins1_dest), .ins1_wr_i(ins1_wr),
    .ins1_valid_i(ins1_valid),
    .free_valid_i(free_valid), .free_preg_i(free_preg),
    .out_valid_o(out_valid), .out_ready_i(out_ready),
    .ins0_rs1_preg_o(o0_rs1), .ins0_rs2_preg_o(o0_rs2),
    .ins0_new_preg_o(o0_new), .ins0_old_preg_o(o0_old), .ins0_alloc_o(o0_alloc),
    .ins1_rs1_preg_o(o1_rs1), .ins1_rs2_preg_o(o1_rs2),
    .ins1_new_preg_o(o1_new), .ins1_old_preg_o(o1_old), .ins1_alloc_o(o1_alloc),
    .ins1_valid_o(o1_valid)
  );

  assign out_word = {o0_rs1, o0_rs2, o0_new, o0_old, o0_alloc,
                     o1_rs1, o1_rs2, o1_new, o1_old, o1_alloc, o1_valid};

  initial begin
    cpu_clock = 1'b0;
    forever #50 cpu_clock = ~cpu_clock;
  end

  task automatic add_row(input string name, input arch_reg_t r0a, r0b, d0, input bit w0,
                         input arch_reg_t r1a, r1b, d1, input bit w1, v1,
                         input bit fr, input preg_t fr_reg, input bit stall);
    row_name[row_cnt]   = name;
    t0_rs1[row_cnt]     = r0a;
    t0_rs2[row_cnt]     = r0b;
    t0_dest[row_cnt]    = d0;
    t0_wr[row_cnt]      = w0;
    t1_rs1[row_cnt]     = r1a;
    t1_rs2[row_cnt]     = r1b;
    t1_dest[row_cnt]    = d1;
    t1_wr[row_cnt]      = w1;
    t1_valid[row_cnt]   = v1;
    t_free[row_cnt]     = fr;
    t_free_reg[row_cnt] = fr_reg;
    t_stall[row_cnt]    = stall;
    row_cnt++;
  endtask

  task automatic load_table();
    // name, ins0 rs1 rs2 dest wr, ins1 rs1 rs2 dest wr valid, free, freed reg, stall check
    add_row("reset_map_a", 1, 2, 3, 1, 4, 5, 6, 1, 1, 0, 0, 0);
    add_row("reset_map_b", 7, 8, 9, 1, 10, 11, 12, 1, 1, 0, 0, 0);
    add_row("ins1_only", 3, 6, 13, 0, 3, 6, 14, 1, 1, 0, 0, 0);
    add_row("src_bypass", 1, 2, 15, 1, 15, 15, 16, 1, 1, 0, 0, 0);
    add_row("dest_bypass", 15, 16, 17, 1, 17, 9, 17, 1, 1, 0, 0, 0);
    add_row("same_dest_seen", 17, 16, 18, 1, 17, 0, 0, 1, 1, 0, 0, 0);
    add_row("x0_dest", 0, 17, 0, 1, 0, 0, 0, 1, 1, 0, 0, 0);
    add_row("no_write", 5, 6, 5, 0, 7, 8, 6, 0, 1, 0, 0, 0);
    add_row("no_ins1", 18, 3, 19, 1, 19, 19, 20, 1, 0, 0, 0, 0);
    add_row("x0_src", 0, 0, 21, 1, 0, 21, 22, 1, 1, 0, 0, 0);
    add_row("flow_a", 3, 9, 3, 1, 3, 1, 4, 1, 1, 0, 0, 0);
    add_row("flow_b", 4, 5, 5, 1, 5, 6, 6, 1, 1, 0, 0, 0);
    add_row("flow_c", 20, 21, 24, 1, 24, 22, 25, 1, 1, 0, 0, 0);
    add_row("flow_d", 25, 24, 26, 1, 26, 26, 27, 1, 1, 0, 0, 0);
    add_row("flow_e", 27, 1, 28, 1, 2, 28, 29, 1, 1, 0, 0, 0);
    add_row("flow_f", 29, 28, 30, 1, 30, 29, 31, 1, 1, 0, 0, 0);
    add_row("flow_g", 31, 30, 1, 1, 1, 31, 2, 1, 1, 0, 0, 0);
    add_row("flow_h", 2, 1, 7, 1, 8, 7, 8, 1, 1, 0, 0, 0);
    add_row("flow_i", 9, 10, 10, 1, 10, 10, 10, 1, 1, 0, 0, 0);
    add_row("last_free", 10, 11, 11, 1, 11, 12, 0, 1, 1, 0, 0, 0);
    // Free list is empty from here until retire returns registers
    add_row("exhausted", 11, 10, 23, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row("free_first", 23, 3, 24, 1, 0, 0, 0, 0, 0, 1, 39, 1);
    add_row("free_second", 24, 0, 0, 0, 0, 0, 0, 0, 0, 1, 32, 0);
    add_row("refill_a", 1, 2, 3, 1, 0, 0, 0, 0, 0, 1, 33, 0);
    add_row("refill_b", 3, 4, 0, 0, 5, 3, 5, 1, 1, 1, 34, 0);
    add_row("refill_c", 5, 6, 6, 1, 6, 6, 0, 1, 1, 1, 35, 0);
    add_row("refill_d", 7, 8, 0, 1, 7, 0, 7, 1, 1, 1, 36, 0);
    add_row("refill_e", 9, 9, 9, 1, 9, 9, 9, 0, 1, 1, 37, 0);
    add_row("refill_f", 12, 13, 12, 1, 0, 0, 0, 0, 0, 1, 38, 0);
    add_row("refill_g", 12, 12, 0, 0, 13, 12, 13, 1, 1, 1, 40, 0);
    add_row("refill_h", 14, 15, 14, 1, 0, 0, 0, 0, 0, 1, 41, 0);
    add_row("refill_i", 15, 16, 15, 1, 14, 15, 0, 0, 0, 1, 42, 0);
    add_row("refill_j", 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 43, 0);
    add_row("refill_k", 16, 17, 16, 1, 16, 16, 17, 1, 1, 1, 44, 0);
    add_row("refill_l", 18, 19, 18, 1, 0, 0, 0, 0, 0, 1, 45, 0);
    add_row("refill_m", 19, 20, 0, 1, 20, 0, 19, 1, 1, 1, 46, 0);
    add_row("refill_n", 21, 22, 21, 1, 0, 0, 0, 0, 0, 1, 47, 0);
    add_row("refill_o", 22, 23, 22, 1, 0, 0, 0, 0, 0, 1, 48, 0);
    add_row("tail_a", 25, 26, 25, 1, 0, 0, 0, 0, 0, 1, 49, 0);
    add_row("tail_b", 26, 27, 26, 1, 25, 26, 0, 1, 1, 1, 50, 0);
  endtask

  // Reference rename model. Pops come out of the FIFO in push order whatever the timing,
  // so every freed register can be queued behind the reset contents up front.
  function automatic void build_expected();
    preg_t map [`RN_ARCH_REGS];
    preg_t free_q [$];
    preg_t new0;
    preg_t new1;
    bit    a0;
    bit    a1;
    for (int i = 0; i < `RN_ARCH_REGS; i++) begin
      map[i] = preg_t'(i);
    end
    for (int i = 0; i < `RN_FREE_DEPTH; i++) begin
      free_q.push_back(preg_t'(`RN_ARCH_REGS + i));
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (t_free[r]) begin
        free_q.push_back(t_free_reg[r]);
      end
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      a0   = t0_wr[r] && (t0_dest[r] != '0);
      a1   = t1_valid[r] && t1_wr[r] && (t1_dest[r] != '0);
      new0 = '0;
      new1 = '0;
      if (a0) begin
        new0 = free_q.pop_front();
      end
      if (a1) begin
        new1 = free_q.pop_front();
      end
      exp_val[r][0] = int'(map[t0_rs1[r]]);
      exp_val[r][1] = int'(map[t0_rs2[r]]);
      exp_val[r][2] = int'(new0);
      exp_val[r][3] = a0 ? int'(map[t0_dest[r]]) : 0;
      exp_val[r][4] = int'(a0);
      exp_val[r][5] = (a0 && t1_rs1[r] == t0_dest[r]) ? int'(new0) : int'(map[t1_rs1[r]]);
      exp_val[r][6] = (a0 && t1_rs2[r] == t0_dest[r]) ? int'(new0) : int'(map[t1_rs2[r]]);
      exp_val[r][7] = int'(new1);
      if (!a1) begin
        exp_val[r][8] = 0;
      end else if (a0 && t1_dest[r] == t0_dest[r]) begin
        exp_val[r][8] = int'(new0);
      end else begin
        exp_val[r][8] = int'(map[t1_dest[r]]);
      end
      exp_val[r][9]  = int'(a1);
      exp_val[r][10] = int'(t1_valid[r]);
      // ins1 written last so it wins on a shared destination
      if (a0) begin
        map[t0_dest[r]] = new0;
      end
      if (a1) begin
        map[t1_dest[r]] = new1;
      end
    end
  endfunction

  task automatic compare_field(input string row, input string field, input int exp_v,
                               input int act_v);
    checks++;
    assert (act_v == exp_v)
      else begin
        errors++;
        $display("CHECK FAILED %s %s: expected %0d, actual %0d", row, field, exp_v, act_v);
      end
  endtask

  task automatic take_bundle();
    int act [NUM_FIELDS];
    act = '{int'(o0_rs1), int'(o0_rs2), int'(o0_new), int'(o0_old), int'(o0_alloc),
            int'(o1_rs1), int'(o1_rs2), int'(o1_new), int'(o1_old), int'(o1_alloc),
            int'(o1_valid)};
    if (out_cnt >= NUM_ROWS) begin
      errors++;
      $display("An extra bundle came out after the last table row");
    end else begin
      for (int f = 0; f < NUM_FIELDS; f++) begin
        compare_field(row_name[out_cnt], field_name[f], exp_val[out_cnt][f], act[f]);
      end
      if (o0_alloc) begin
        seen[o0_new] = 1'b1;
      end
      if (o1_alloc) begin
        seen[o1_new] = 1'b1;
      end
    end
    out_cnt++;
  endtask

  // Outputs settle after the rising edge, so the monitor looks at the falling edge
  always @(negedge cpu_clock) begin
    if (!rst) begin
      if (holding) begin
        checks++;
        assert (out_valid && out_word == held_word)
          else begin
            errors++;
            $display("CHECK FAILED stall_hold bundle %0d: expected %h, actual %h",
                     out_cnt, held_word, out_word);
          end
      end
      if (out_valid && out_ready) begin
        take_bundle();
        holding = 1'b0;
      end else begin
        holding   = out_valid;
        held_word = out_word;
      end
    end
  end

  task automatic send_bundle(input int r);
    in_valid   = 1'b1;
    ins0_rs1   = t0_rs1[r];
    ins0_rs2   = t0_rs2[r];
    ins0_dest  = t0_dest[r];
    ins0_wr    = t0_wr[r];
    ins1_rs1   = t1_rs1[r];
    ins1_rs2   = t1_rs2[r];
    ins1_dest  = t1_dest[r];
    ins1_wr    = t1_wr[r];
    ins1_valid = t1_valid[r];
    @(negedge cpu_clock);
    while (!in_ready) begin
      @(negedge cpu_clock);
    end
    @(posedge cpu_clock);
    #10;
    in_valid = 1'b0;
  endtask

  // Retire returns a register only after it has come out allocated
  task automatic return_reg(input preg_t r);
    while (!seen[r]) begin
      @(posedge cpu_clock);
      #10;
    end
    free_valid = 1'b1;
    free_preg  = r;
    @(posedge cpu_clock);
    #10;
    free_valid = 1'b0;
  endtask

  task automatic check_stall(input int row);
    while (out_cnt < row) begin
      @(posedge cpu_clock);
      #10;
    end
    repeat (5) @(posedge cpu_clock);
    #10;
    checks++;
    assert (out_cnt == row && !out_valid)
      else begin
        errors++;
        $display("CHECK FAILED %s: expected %0d bundles and out_valid 0, actual %0d and %0d",
                 row_name[row], row, out_cnt, out_valid);
      end
  endtask

  initial begin
    out_ready = 1'b0;
    void'($urandom(32'h92bd9e63));
    forever begin
      @(posedge cpu_clock);
      #10;
      // Consumer stalls about 30% of the cycles
      out_ready = ($urandom % 100) >= 30;
    end
  end

  always @(posedge cpu_clock) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, %0d of %0d bundles came out",
               cycle_cnt, out_cnt, NUM_ROWS);
      for (int k = out_cnt; k < NUM_ROWS; k++) begin
        $display("Bundle %0d (%s) never came out", k, row_name[k]);
      end
      $display("Checks: %0d, errors: %0d", checks, errors + 1);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    rst        = 1'b1;
    in_valid   = 1'b0;
    ins0_rs1   = '0;
    ins0_rs2   = '0;
    ins0_dest  = '0;
    ins0_wr    = 1'b0;
    ins1_rs1   = '0;
    ins1_rs2   = '0;
    ins1_dest  = '0;
    ins1_wr    = 1'b0;
    ins1_valid = 1'b0;
    free_valid = 1'b0;
    free_preg  = '0;
    load_table();
    build_expected();
    repeat (16) @(posedge cpu_clock);
    #10;
    rst = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (t_stall[r]) begin
        check_stall(r - 1);
      end
      if (t_free[r]) begin
        return_reg(t_free_reg[r]);
      end
      send_bundle(r);
    end
    while (out_cnt < NUM_ROWS) begin
      @(posedge cpu_clock);
    end
    repeat (3) @(posedge cpu_clock);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/rn_pkg.sv
design/rn_skid_buffer.sv
design/rn_map_table.sv
design/rn_free_list.sv
design/rn_dispatch_reg.sv
design/rename_stage.sv
tests/tb_rename_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the rename stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f sim.f --top-module tb_rename_stage -o tb_rename_stage

./obj_dir/tb_rename_stage 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished without failures"
